// ==== host_link.sv ====
module host_link #(
	parameter int MAX_CREDITS = 2
) (
	input  logic                clk,
	input  logic                rst_n,
	input  mem_pkg::addr_t      raw_addr,
	input  mem_pkg::addr_t      addr_offset,
	input  logic                send_req,
	input  logic                send_write,
	input  mem_pkg::line_t      line,
	input  logic                credit_return,
	input  mem_pkg::host_rsp_t  host_rsp,
	output mem_pkg::host_req_t  host_req,
	output logic                req_sent,
	output logic                rsp_valid,
	output mem_pkg::line_t      rsp_line
);

	localparam int CNT_W = $clog2(MAX_CREDITS + 1);

	// Credits currently held
	logic [CNT_W-1:0] credits;

	// Registered corrected line address
	mem_pkg::addr_t corr_addr;

	// Read request out with its response not yet back
	logic rd_pending;

	logic req_fire;

	// raw_addr is steady from the first op cycle and a request leaves one cycle later at the
	// earliest, so the registered sum is always current
	always_ff @(posedge clk) begin
		corr_addr <= raw_addr + addr_offset;
	end

	// No request leaves without a credit
	assign req_fire = send_req && (credits != '0);
	assign req_sent = req_fire;

	// Request channel
	always_comb begin
		host_req.valid = req_fire;
		host_req.write = send_write;
		host_req.addr  = corr_addr;
		host_req.line  = line;
	end

	// A return and a spend in the same cycle cancel out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CNT_W'(MAX_CREDITS);
		end else begin
			case ({credit_return, req_fire})
				2'b10:   credits <= credits + CNT_W'(1);
				2'b01:   credits <= credits - CNT_W'(1);
				default: credits <= credits;
			endcase
		end
	end

	// Track the open read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_pending <= 1'b0;
		end else if (req_fire && !send_write) begin
			rd_pending <= 1'b1;
		end else if (host_rsp.valid) begin
			rd_pending <= 1'b0;
		end
	end

	// The line buffer is the landing register for responses
	// Stray responses with no read open are dropped
	assign rsp_valid = host_rsp.valid && rd_pending;
	assign rsp_line  = host_rsp.line;

	// Host never hands back more credits than it was given
	a_credit_max: assert property (
		@(posedge clk) disable iff (!rst_n)
		credit_return |-> (req_fire || credits < CNT_W'(MAX_CREDITS))
	) else $error("host_link: credit overflow, count %0d", credits);

	// Count stays within range across cycles
	a_credit_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		credits <= CNT_W'(MAX_CREDITS)
	) else $error("host_link: credit count %0d out of range", credits);

	// Line responses only arrive for an open read
	a_rsp_expected: assert property (
		@(posedge clk) disable iff (!rst_n)
		host_rsp.valid |-> rd_pending
	) else $error("host_link: host response with no read outstanding");

endmodule

// ==== line_buffer.sv ====
module line_buffer (
	input  logic            clk,
	input  logic            rst_n,
	input  mem_pkg::word_t  word_in,
	input  logic            ld_word,
	input  logic            ld_line,
	input  logic            step,
	input  logic            clr_idx,
	input  mem_pkg::line_t  rsp_line,
	output mem_pkg::line_t  line,
	output mem_pkg::word_t  word_out,
	output logic            idx_last
);

	// Line storage, payload only
	mem_pkg::line_t line_q;

	// Current word slot
	mem_pkg::widx_t idx;

	// Line contents
	always_ff @(posedge clk) begin
		if (ld_line) begin
			// Full line from the host on a read
			line_q <= rsp_line;
		end else if (ld_word) begin
			// Pack the processor word into the selected slot
			line_q[idx*mem_pkg::WORD_W +: mem_pkg::WORD_W] <= word_in;
		end
	end

	// Word index
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (clr_idx) begin
			idx <= '0;
		end else if (ld_word || step) begin
			// Wraps back to slot 0 after the last word
			idx <= idx + mem_pkg::widx_t'(1);
		end
	end

	// Whole line towards the host request
	assign line = line_q;

	// Slot at the current index towards the processor
	assign word_out = line_q[idx*mem_pkg::WORD_W +: mem_pkg::WORD_W];

	// Last slot of the line
	assign idx_last = (idx == mem_pkg::widx_t'(mem_pkg::LINE_WORDS - 1));

	// Fill and load come from different phases of the control FSM
	a_load_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(ld_word && ld_line)
	) else $error("line_buffer: ld_word and ld_line high together");

	// A loaded line is always drained from slot 0
	a_load_at_zero: assert property (
		@(posedge clk) disable iff (!rst_n)
		ld_line |-> (idx == '0)
	) else $error("line_buffer: line loaded with index %0d", idx);

endmodule

// ==== mem_ctrl.sv ====
module mem_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              host_init,
	input  mem_pkg::mem_op_t  op,
	input  logic              idx_last,
	input  logic              req_sent,
	input  logic              rsp_valid,
	output logic              ready,
	output logic              word_ack,
	output logic              rd_valid,
	output logic              tx_done,
	output logic              ld_word,
	output logic              ld_line,
	output logic              step,
	output logic              clr_idx,
	output logic              send_req,
	output logic              send_write
);

	mem_pkg::ctrl_state_t state;
	mem_pkg::ctrl_state_t state_next;

	// Operation kind latched when the operation is accepted
	logic op_write;

	// State register and latched operation kind
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= mem_pkg::ST_STARTUP;
			op_write <= 1'b0;
		end else begin
			state <= state_next;
			// Only sampled in READY, so a later glitch on op cannot flip the kind
			if (state == mem_pkg::ST_READY) begin
				op_write <= (op == mem_pkg::OP_WRITE);
			end
		end
	end

	// Next state and handshake decode
	always_comb begin
		state_next = state;
		// Ready stays up once the host has come out of init
		ready      = (state != mem_pkg::ST_STARTUP);
		word_ack   = 1'b0;
		rd_valid   = 1'b0;
		tx_done    = 1'b0;
		ld_word    = 1'b0;
		ld_line    = 1'b0;
		step       = 1'b0;
		clr_idx    = 1'b0;
		send_req   = 1'b0;
		send_write = 1'b0;

		case (state)
			mem_pkg::ST_STARTUP: begin
				// Wait for the host to report that it is initialised
				if (host_init) begin
					state_next = mem_pkg::ST_READY;
				end
			end

			mem_pkg::ST_READY: begin
				// Every operation starts from word slot 0
				clr_idx = 1'b1;
				if (op == mem_pkg::OP_WRITE) begin
					state_next = mem_pkg::ST_FILL;
				end else if (op == mem_pkg::OP_READ) begin
					state_next = mem_pkg::ST_HOSTREQ;
				end
			end

			mem_pkg::ST_FILL: begin
				// One word accepted per cycle
				word_ack = 1'b1;
				ld_word  = 1'b1;
				if (idx_last) begin
					state_next = mem_pkg::ST_HOSTREQ;
				end
			end

			mem_pkg::ST_HOSTREQ: begin
				// Request stays pending here until the link has a credit
				send_req   = 1'b1;
				send_write = op_write;
				if (req_sent) begin
					if (op_write) begin
						// Write is finished once the line leaves
						tx_done    = 1'b1;
						state_next = mem_pkg::ST_READY;
					end else begin
						state_next = mem_pkg::ST_WAITRSP;
					end
				end
			end

			mem_pkg::ST_WAITRSP: begin
				// Response cannot be refused and goes straight into the buffer
				if (rsp_valid) begin
					ld_line    = 1'b1;
					state_next = mem_pkg::ST_DRAIN;
				end
			end

			mem_pkg::ST_DRAIN: begin
				// Hand back one word per cycle starting with word 0
				rd_valid = 1'b1;
				step     = 1'b1;
				if (idx_last) begin
					tx_done    = 1'b1;
					state_next = mem_pkg::ST_READY;
				end
			end

			default: begin
				state_next = mem_pkg::ST_STARTUP;
			end
		endcase
	end

	// A write never waits for a line response
	a_no_wait_on_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state == mem_pkg::ST_WAITRSP) |-> (op != mem_pkg::OP_WRITE)
	) else $error("mem_ctrl: entered ST_WAITRSP on a write");

	// Word handshakes only on a write and drain handshakes only on a read
	a_ack_rd_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		(!word_ack || op == mem_pkg::OP_WRITE) && (!rd_valid || op == mem_pkg::OP_READ)
	) else $error("mem_ctrl: word_ack or rd_valid does not match the processor op");

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

	// Processor word, host cache line and byte address widths
	localparam int WORD_W = 32;
	localparam int LINE_W = 128;
	localparam int ADDR_W = 32;

	// Words carried by one cache line
	localparam int LINE_WORDS = LINE_W / WORD_W;

	typedef logic [WORD_W-1:0] word_t;

	// Word 0 sits in the lowest bits of the line
	typedef logic [LINE_W-1:0] line_t;

	typedef logic [ADDR_W-1:0] addr_t;

	// Word slot within a line
	typedef logic [1:0] widx_t;

	// Processor operation codes, value 2 falls back to idle
	typedef enum logic [1:0] {
		OP_IDLE  = 2'd0,
		OP_READ  = 2'd1,
		OP_WRITE = 2'd3
	} mem_op_t;

	// Control FSM states
	typedef enum logic [2:0] {
		ST_STARTUP = 3'd0,
		ST_READY   = 3'd1,
		ST_FILL    = 3'd2,
		ST_HOSTREQ = 3'd3,
		ST_WAITRSP = 3'd4,
		ST_DRAIN   = 3'd5
	} ctrl_state_t;

	// One line request towards the host, valid for a single cycle
	typedef struct packed {
		logic  valid;
		logic  write;
		addr_t addr;
		line_t line;
	} host_req_t;

	// Line response from the host for the oldest open read
	typedef struct packed {
		logic  valid;
		line_t line;
	} host_rsp_t;

endpackage

// ==== mem_subsys.sv ====
module mem_subsys #(
	parameter int MAX_CREDITS = 2
) (
	input  logic                clk,
	input  logic                rst_n,
	// Processor side
	input  mem_pkg::mem_op_t    op,
	input  mem_pkg::addr_t      raw_addr,
	input  mem_pkg::word_t      word_in,
	output logic                ready,
	output logic                word_ack,
	output logic                rd_valid,
	output mem_pkg::word_t      word_out,
	output logic                tx_done,
	// Host side
	input  logic                host_init,
	input  mem_pkg::addr_t      addr_offset,
	input  logic                credit_return,
	input  mem_pkg::host_rsp_t  host_rsp,
	output mem_pkg::host_req_t  host_req
);

	// Control to line buffer
	logic ld_word;
	logic ld_line;
	logic step;
	logic clr_idx;
	logic idx_last;

	// Control to host link
	logic send_req;
	logic send_write;
	logic req_sent;
	logic rsp_valid;

	// Line data between buffer and link
	mem_pkg::line_t buf_line;
	mem_pkg::line_t rsp_line;

	mem_ctrl u_mem_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.host_init  (host_init),
		.op         (op),
		.idx_last   (idx_last),
		.req_sent   (req_sent),
		.rsp_valid  (rsp_valid),
		.ready      (ready),
		.word_ack   (word_ack),
		.rd_valid   (rd_valid),
		.tx_done    (tx_done),
		.ld_word    (ld_word),
		.ld_line    (ld_line),
		.step       (step),
		.clr_idx    (clr_idx),
		.send_req   (send_req),
		.send_write (send_write)
	);

	line_buffer u_line_buffer (
		.clk      (clk),
		.rst_n    (rst_n),
		.word_in  (word_in),
		.ld_word  (ld_word),
		.ld_line  (ld_line),
		.step     (step),
		.clr_idx  (clr_idx),
		.rsp_line (rsp_line),
		.line     (buf_line),
		.word_out (word_out),
		.idx_last (idx_last)
	);

	host_link #(
		.MAX_CREDITS (MAX_CREDITS)
	) u_host_link (
		.clk           (clk),
		.rst_n         (rst_n),
		.raw_addr      (raw_addr),
		.addr_offset   (addr_offset),
		.send_req      (send_req),
		.send_write    (send_write),
		.line          (buf_line),
		.credit_return (credit_return),
		.host_rsp      (host_rsp),
		.host_req      (host_req),
		.req_sent      (req_sent),
		.rsp_valid     (rsp_valid),
		.rsp_line      (rsp_line)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mem_subsys -f tb.f -o sim_tb

# Run and keep the output for the pass search
out=$(./obj_dir/sim_tb 2>&1) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

// ==== tb.f ====
mem_pkg.sv
mem_ctrl.sv
line_buffer.sv
host_link.sv
mem_subsys.sv
tb_host_model.sv
tb_mem_subsys.sv

// ==== tb_host_model.sv ====
module tb_host_model (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                hold_credits,
	input  mem_pkg::host_req_t  host_req,
	output logic                credit_return,
	output mem_pkg::host_rsp_t  host_rsp
);

	// Line storage keyed by line address
	mem_pkg::line_t mem [mem_pkg::addr_t];

	// Cycle numbers at which each spent credit may go back
	longint credit_due[$];
	longint cyc;

	// Single open read, only one operation is in flight at a time
	logic           rsp_pend;
	longint         rsp_at;
	mem_pkg::line_t rsp_data;

	initial begin
		credit_return = 1'b0;
		host_rsp      = '0;
	end

	// Unwritten lines read back as four copies of their address
	function automatic mem_pkg::line_t read_line(input mem_pkg::addr_t a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return {mem_pkg::LINE_WORDS{a}};
	endfunction

	always @(posedge clk) begin
		int slot;
		slot = -1;
		// Both outputs are single cycle pulses
		credit_return <= 1'b0;
		host_rsp      <= '0;
		if (!rst_n) begin
			cyc      = 0;
			rsp_pend = 1'b0;
			credit_due.delete();
		end else begin
			cyc++;
			if (host_req.valid) begin
				// Credit comes back 1 to 8 cycles later
				credit_due.push_back(cyc + longint'($urandom_range(8, 1)));
				if (host_req.write) begin
					mem[host_req.addr] = host_req.line;
				end else begin
					// Read answered 3 to 10 cycles later
					rsp_pend = 1'b1;
					rsp_at   = cyc + longint'($urandom_range(10, 3));
					rsp_data = read_line(host_req.addr);
				end
			end
			// At most one credit per cycle, held ones pile up
			if (!hold_credits) begin
				foreach (credit_due[i]) begin
					if (slot < 0 && credit_due[i] <= cyc) begin
						slot = i;
					end
				end
				if (slot >= 0) begin
					credit_due.delete(slot);
					credit_return <= 1'b1;
				end
			end
			if (rsp_pend && cyc >= rsp_at) begin
				rsp_pend       = 1'b0;
				host_rsp.valid <= 1'b1;
				host_rsp.line  <= rsp_data;
			end
		end
	end

endmodule

// ==== tb_mem_subsys.sv ====
module tb_mem_subsys;

	localparam int MAX_CREDITS = 2;
	// Operations issued over all tests and the cycle budget of each
	localparam int NUM_OPS = 27;
	localparam int OP_BUDGET = 200;

	logic               clk;
	logic               rst_n;
	mem_pkg::mem_op_t   op;
	mem_pkg::addr_t     raw_addr;
	mem_pkg::word_t     word_in;
	logic               ready;
	logic               word_ack;
	logic               rd_valid;
	mem_pkg::word_t     word_out;
	logic               tx_done;
	logic               host_init;
	mem_pkg::addr_t     addr_offset;
	logic               credit_return;
	mem_pkg::host_rsp_t host_rsp;
	mem_pkg::host_req_t host_req;

	logic hold_credits;
	// Window in which the DUT must sit in ST_HOSTREQ without credits
	logic hold_check;
	logic timing_check;
	logic cur_write;
	mem_pkg::line_t exp_line;
	mem_pkg::word_t exp_word;
	// Lines written so far, keyed by corrected address
	mem_pkg::line_t shadow [mem_pkg::addr_t];
	int rd_cnt;
	int op_cycles;
	int outstanding;
	int err_cnt;
	int tests_run;
	int tests_failed;
	mem_pkg::ctrl_state_t fsm_state;

	mem_subsys #(.MAX_CREDITS(MAX_CREDITS)) u_mem_subsys (
		.clk(clk), .rst_n(rst_n), .op(op), .raw_addr(raw_addr), .word_in(word_in),
		.ready(ready), .word_ack(word_ack), .rd_valid(rd_valid), .word_out(word_out),
		.tx_done(tx_done), .host_init(host_init), .addr_offset(addr_offset),
		.credit_return(credit_return), .host_rsp(host_rsp), .host_req(host_req)
	);

	tb_host_model u_host (
		.clk(clk), .rst_n(rst_n), .hold_credits(hold_credits), .host_req(host_req),
		.credit_return(credit_return), .host_rsp(host_rsp)
	);

	assign fsm_state = u_mem_subsys.u_mem_ctrl.state;
	// Word k of a line sits at bits k*WORD_W upwards
	assign exp_word = exp_line[rd_cnt*mem_pkg::WORD_W +: mem_pkg::WORD_W];

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Read word counter, cycles with op active, credits spent and not yet back
	always @(posedge clk) begin
		if (!rst_n) begin
			rd_cnt      <= 0;
			op_cycles   <= 0;
			outstanding <= 0;
		end else begin
			rd_cnt      <= tx_done ? 0 : (rd_valid ? rd_cnt + 1 : rd_cnt);
			op_cycles   <= (op == mem_pkg::OP_IDLE) ? 0 : op_cycles + 1;
			outstanding <= outstanding + int'(host_req.valid) - int'(credit_return);
		end
	end

	task automatic log_error(input string msg);
		$display("%s", msg);
		err_cnt++;
	endtask

	a_ready_rst: assert property (@(posedge clk) !rst_n |-> !ready)
		else log_error("ready high during reset");
	a_ready_early: assert property (@(posedge clk) disable iff (!rst_n) !host_init |=> !ready)
		else log_error("ready rose before host_init was seen");
	a_ready_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(host_init) |-> !ready ##1 ready)
		else log_error("ready did not rise on the cycle after host_init");
	a_addr: assert property (@(posedge clk) disable iff (!rst_n)
		host_req.valid |-> host_req.addr == raw_addr + addr_offset)
		else log_error($sformatf("MISMATCH host_req.addr: got %h expected %h",
			$sampled(host_req.addr), $sampled(raw_addr) + $sampled(addr_offset)));
	a_credit: assert property (@(posedge clk) disable iff (!rst_n)
		host_req.valid |-> outstanding < MAX_CREDITS)
		else log_error("request sent with every credit already spent");
	// While out of credits only ready may be up
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		hold_check |-> ready && !word_ack && !rd_valid && !tx_done && !host_req.valid &&
		fsm_state == mem_pkg::ST_HOSTREQ)
		else log_error($sformatf("DUT did not wait without credits, FSM in %s",
			fsm_state.name()));
	a_rd_len: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid |-> rd_cnt < mem_pkg::LINE_WORDS && tx_done == (rd_cnt == mem_pkg::LINE_WORDS - 1))
		else log_error("read drain longer than a line or tx_done not on the last word");
	a_rd_data: assert property (@(posedge clk) disable iff (!rst_n) rd_valid |-> word_out == exp_word)
		else log_error($sformatf("MISMATCH word_out: got %h expected %h",
			$sampled(word_out), $sampled(exp_word)));
	a_rd_gap: assert property (@(posedge clk) disable iff (!rst_n) rd_valid && !tx_done |=> rd_valid)
		else log_error("rd_valid dropped before the last word of the line");
	a_rd_done: assert property (@(posedge clk) disable iff (!rst_n)
		tx_done && !cur_write |-> rd_valid)
		else log_error("read finished without handing back its words");
	// Op cycle count includes the tx_done cycle itself
	a_wr_time: assert property (@(posedge clk) disable iff (!rst_n)
		timing_check && tx_done && cur_write |-> op_cycles + 1 == mem_pkg::LINE_WORDS + 2)
		else log_error($sformatf("MISMATCH write latency: got %h expected %h",
			$sampled(op_cycles) + 1, mem_pkg::LINE_WORDS + 2));

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
	endtask

	function automatic mem_pkg::line_t rand_line();
		mem_pkg::line_t l;
		int i;
		for (i = 0; i < mem_pkg::LINE_WORDS; i++) begin
			l[i*mem_pkg::WORD_W +: mem_pkg::WORD_W] = $urandom();
		end
		return l;
	endfunction

	// One of 16 aligned lines above base
	function automatic mem_pkg::addr_t line_addr(input mem_pkg::addr_t base);
		return base + mem_pkg::addr_t'($urandom_range(15, 0) << 4);
	endfunction

	task automatic do_write(input mem_pkg::addr_t a, input mem_pkg::line_t data);
		int k;
		int n;
		k = 0;
		n = 0;
		cur_write <= 1'b1;
		raw_addr  <= a;
		op        <= mem_pkg::OP_WRITE;
		word_in   <= data[mem_pkg::WORD_W-1:0];
		@(posedge clk);
		while (!tx_done && n < OP_BUDGET) begin
			// Next word goes out once the current one is acknowledged
			if (word_ack && k < mem_pkg::LINE_WORDS - 1) begin
				k++;
				word_in <= data[k*mem_pkg::WORD_W +: mem_pkg::WORD_W];
			end
			n++;
			@(posedge clk);
		end
		if (!tx_done) begin
			log_error($sformatf("write to %h got no tx_done within %0d cycles", a, OP_BUDGET));
		end
		shadow[a + addr_offset] = data;
		op <= mem_pkg::OP_IDLE;
		@(posedge clk);
	endtask

	task automatic do_read(input mem_pkg::addr_t a);
		mem_pkg::addr_t la;
		int n;
		n = 0;
		la = a + addr_offset;
		exp_line = shadow.exists(la) ? shadow[la] : {mem_pkg::LINE_WORDS{la}};
		cur_write <= 1'b0;
		raw_addr  <= a;
		op        <= mem_pkg::OP_READ;
		@(posedge clk);
		while (!tx_done && n < OP_BUDGET) begin
			n++;
			@(posedge clk);
		end
		if (!tx_done) begin
			log_error($sformatf("read of %h got no tx_done within %0d cycles", a, OP_BUDGET));
		end
		op <= mem_pkg::OP_IDLE;
		@(posedge clk);
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (err_cnt == err_before) begin
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, err_cnt - err_before);
		end
	endtask

	initial begin
		int err_before;
		int i;
		int n;
		mem_pkg::addr_t a;
		void'($urandom(40));
		rst_n        = 1'b0;
		op           = mem_pkg::OP_IDLE;
		raw_addr     = '0;
		word_in      = '0;
		host_init    = 1'b0;
		addr_offset  = mem_pkg::addr_t'($urandom_range(255, 1) << 12);
		hold_credits = 1'b0;
		hold_check   = 1'b0;
		timing_check = 1'b1;
		cur_write    = 1'b0;
		exp_line     = '0;
		err_cnt      = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// Startup, ready must wait for host_init
		err_before = err_cnt;
		idle(3);
		host_init <= 1'b1;
		n = 0;
		@(posedge clk);
		while (!ready && n < OP_BUDGET) begin
			n++;
			@(posedge clk);
		end
		if (!ready) begin
			log_error("ready never rose after host_init");
		end
		end_test("startup", err_before);

		err_before = err_cnt;
		a = line_addr(32'h0000_1000);
		do_write(a, rand_line());
		do_read(a);
		end_test("write then read back", err_before);

		err_before = err_cnt;
		do_read(line_addr(32'h0080_0000));
		end_test("unwritten line", err_before);

		// Back-pressure, third write stalls until credits flow again
		err_before = err_cnt;
		idle(20);
		timing_check <= 1'b0;
		hold_credits <= 1'b1;
		do_write(32'h0000_2000, rand_line());
		do_write(32'h0000_2010, rand_line());
		fork
			do_write(32'h0000_2020, rand_line());
			begin
				idle(12);
				hold_check <= 1'b1;
				idle(20);
				hold_check   <= 1'b0;
				hold_credits <= 1'b0;
			end
		join
		do_read(32'h0000_2020);
		idle(20);
		timing_check <= 1'b1;
		end_test("credit back-pressure", err_before);

		err_before = err_cnt;
		for (i = 0; i < 20; i++) begin
			a = line_addr(32'h0000_3000);
			if ($urandom_range(1, 0) == 1) begin
				do_write(a, rand_line());
			end else begin
				do_read(a);
			end
		end
		end_test("random mixed sequence", err_before);

		idle(5);
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Backstop in case an operation hangs
	initial begin
		repeat (OP_BUDGET * NUM_OPS) @(posedge clk);
		$display("Watchdog expired after %0d cycles, run did not complete", OP_BUDGET * NUM_OPS);
		$display("Finished with errors");
		$finish;
	end

endmodule
